/* all.f */
+incdir+include
source/cdb_pkg.sv
source/stage_fifo.sv
source/alu_stage.sv
source/cdb_arbiter.sv
source/wb_backend_top.sv
verif/wb_properties.sv
verif/wb_monitor.sv
verif/tb_wb_backend.sv

/* include/cdb_params.svh */
`ifndef CDB_PARAMS_SVH
`define CDB_PARAMS_SVH

// functional-unit lanes feeding the CDB
`define CDB_FU_COUNT 4

// results broadcast per cycle
`define CDB_PORT_COUNT 2

// integer datapath width
`define CDB_DATA_W 32

// rob tag width, upper 2 bits name the lane in this slice
`define CDB_ROB_ID_W 6

// entries per stage_fifo
`define CDB_FIFO_DEPTH 2

`endif

/* run.sh */
#!/bin/sh
# build the testbench with verilator and run it once
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_wb_backend -Mdir obj_dir -f all.f

# the simulation verdict comes from its output, not its exit status
sim_out=$(./obj_dir/Vtb_wb_backend +verilator+error+limit+100 || true)
echo "$sim_out"
echo "$sim_out" | grep -qx "Test OK"

/* source/alu_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cdb_params.svh"

module alu_stage (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   flush_i,

    input  logic                   in_valid_i,
    output logic                   in_ready_o,
    input  cdb_pkg::issue_pkt_t    in_pkt_i,

    output logic                   out_valid_o,
    input  logic                   out_ready_i,
    output cdb_pkg::result_pkt_t   out_pkt_o
);

    localparam int DATA_W  = `CDB_DATA_W;
    localparam int SHAMT_W = $clog2(`CDB_DATA_W);

    logic                 out_valid_q;
    cdb_pkg::result_pkt_t out_pkt_q;

    logic [DATA_W-1:0]  alu_res;
    logic [SHAMT_W-1:0] shamt;
    logic               accept;

    assign shamt = in_pkt_i.src_b[SHAMT_W-1:0];

    // execute
    always_comb begin
        case (in_pkt_i.op)
            cdb_pkg::alu_add: alu_res = in_pkt_i.src_a + in_pkt_i.src_b;
            cdb_pkg::alu_sub: alu_res = in_pkt_i.src_a - in_pkt_i.src_b;
            cdb_pkg::alu_and: alu_res = in_pkt_i.src_a & in_pkt_i.src_b;
            cdb_pkg::alu_or:  alu_res = in_pkt_i.src_a | in_pkt_i.src_b;
            cdb_pkg::alu_xor: alu_res = in_pkt_i.src_a ^ in_pkt_i.src_b;
            cdb_pkg::alu_sll: alu_res = in_pkt_i.src_a << shamt;
            cdb_pkg::alu_srl: alu_res = in_pkt_i.src_a >> shamt; // logical
            cdb_pkg::alu_slt: begin
                alu_res = {{(DATA_W - 1){1'b0}},
                           ($signed(in_pkt_i.src_a) < $signed(in_pkt_i.src_b))};
            end
            default: alu_res = '0;
        endcase
    end

    // empty, or the held result drains this cycle
    assign in_ready_o = ~out_valid_q | out_ready_i;
    assign accept     = in_valid_i & in_ready_o;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            out_valid_q <= 1'b0;
        end else if (flush_i) begin
            out_valid_q <= 1'b0;
        end else if (in_ready_o) begin
            out_valid_q <= in_valid_i; // refill or go empty
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out_pkt_q.rob_id <= in_pkt_i.rob_id;
            out_pkt_q.data   <= alu_res;
        end
    end

    assign out_valid_o = out_valid_q;
    assign out_pkt_o   = out_pkt_q;

endmodule

`default_nettype wire

/* source/cdb_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cdb_params.svh"

module cdb_arbiter (
    input  logic                                           clk,
    input  logic                                           rst_n_i,
    input  logic                                           flush_i,

    input  logic [`CDB_FU_COUNT-1:0]                       req_valid_i,
    output logic [`CDB_FU_COUNT-1:0]                       req_pop_o,
    input  cdb_pkg::result_pkt_t [`CDB_FU_COUNT-1:0]       req_pkt_i,

    output cdb_pkg::cdb_info_t   [`CDB_PORT_COUNT-1:0]     cdb_o
);

    localparam int FU_COUNT   = `CDB_FU_COUNT;
    localparam int PORT_COUNT = `CDB_PORT_COUNT;
    localparam int IDX_W      = (FU_COUNT > 1) ? $clog2(FU_COUNT) : 1;

    logic [IDX_W-1:0] rr_ptr_q;           // lane with highest priority
    logic [IDX_W-1:0] rr_ptr_nxt;

    logic [FU_COUNT-1:0]                grant;
    logic [PORT_COUNT-1:0][IDX_W-1:0]   sel_idx;    // lane feeding each port
    logic [PORT_COUNT-1:0]              sel_vld;
    logic [IDX_W-1:0]                   last_idx;
    logic                               any_grant;

    cdb_pkg::cdb_info_t [PORT_COUNT-1:0] cdb_q;

    // walk the lanes from the pointer, fill ports in order
    always_comb begin
        int               n_gnt;
        logic [IDX_W-1:0] idx;

        n_gnt    = 0;
        idx      = '0;
        grant    = '0;
        sel_idx  = '0;
        sel_vld  = '0;
        last_idx = rr_ptr_q;
        for (int k = 0; k < FU_COUNT; k++) begin
            idx = IDX_W'((int'(rr_ptr_q) + k) % FU_COUNT);
            if (req_valid_i[idx] && (n_gnt < PORT_COUNT)) begin
                grant[idx]     = 1'b1;
                sel_idx[n_gnt] = idx;
                sel_vld[n_gnt] = 1'b1;
                last_idx       = idx;
                n_gnt          = n_gnt + 1;
            end
        end
    end

    assign any_grant = |grant;
    assign req_pop_o = grant;

    // next round starts just past the last winner
    always_comb begin
        if (any_grant) begin
            rr_ptr_nxt = IDX_W'((int'(last_idx) + 1) % FU_COUNT);
        end else begin
            rr_ptr_nxt = rr_ptr_q;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rr_ptr_q <= '0;
        end else if (flush_i) begin
            rr_ptr_q <= '0;
        end else begin
            rr_ptr_q <= rr_ptr_nxt;
        end
    end

    // broadcast registers
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cdb_q <= '0;
        end else if (flush_i) begin
            cdb_q <= '0;
        end else begin
            for (int p = 0; p < PORT_COUNT; p++) begin
                cdb_q[p].valid  <= sel_vld[p];
                cdb_q[p].rob_id <= req_pkt_i[sel_idx[p]].rob_id;
                cdb_q[p].data   <= req_pkt_i[sel_idx[p]].data;
            end
        end
    end

    assign cdb_o = cdb_q;

endmodule

`default_nettype wire

/* source/cdb_pkg.sv */
`default_nettype none

`include "cdb_params.svh"

package cdb_pkg;

    // integer alu operations
    typedef enum logic [2:0] {
        alu_add = 3'd0,
        alu_sub = 3'd1,
        alu_and = 3'd2,
        alu_or  = 3'd3,
        alu_xor = 3'd4,
        alu_sll = 3'd5, // shift amount from low bits of src_b
        alu_srl = 3'd6,
        alu_slt = 3'd7  // signed compare, result 1 or 0
    } alu_op_e;

    // operation handed to a lane
    typedef struct packed {
        alu_op_e                   op;
        logic [`CDB_DATA_W-1:0]    src_a;
        logic [`CDB_DATA_W-1:0]    src_b;
        logic [`CDB_ROB_ID_W-1:0]  rob_id;
    } issue_pkt_t;

    // executed result waiting for the bus
    typedef struct packed {
        logic [`CDB_ROB_ID_W-1:0]  rob_id;
        logic [`CDB_DATA_W-1:0]    data;
    } result_pkt_t;

    // one port of the common data bus
    typedef struct packed {
        logic                      valid;
        logic [`CDB_ROB_ID_W-1:0]  rob_id;
        logic [`CDB_DATA_W-1:0]    data;
    } cdb_info_t;

endpackage

`default_nettype wire

/* source/stage_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cdb_params.svh"

module stage_fifo #(
    parameter type T = logic
) (
    input  logic clk,
    input  logic rst_n_i,
    input  logic flush_i,

    input  logic in_valid_i,
    output logic in_ready_o,
    input  T     in_data_i,

    output logic out_valid_o,
    input  logic out_ready_i,
    output T     out_data_o
);

    localparam int DEPTH = `CDB_FIFO_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    T               mem_q [DEPTH];
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W-1:0] wr_ptr_q;
    logic [CNT_W-1:0] count_q;

    logic push;
    logic pop;

    // no bypass, an entry shows up the cycle after it is written
    assign in_ready_o  = (count_q != CNT_W'(DEPTH));
    assign out_valid_o = (count_q != '0);
    assign out_data_o  = mem_q[rd_ptr_q];

    assign push = in_valid_i & in_ready_o;
    assign pop  = out_valid_o & out_ready_i;

    always_ff @(posedge clk) begin
        if (push) begin
            mem_q[wr_ptr_q] <= in_data_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            // drop everything queued
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q; // idle or push and pop together
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/wb_backend_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cdb_params.svh"

module wb_backend_top (
    input  logic                                         clk,
    input  logic                                         rst_n_i,
    input  logic                                         flush_i,

    input  logic [`CDB_FU_COUNT-1:0]                     issue_valid_i,
    output logic [`CDB_FU_COUNT-1:0]                     issue_ready_o,
    input  cdb_pkg::issue_pkt_t  [`CDB_FU_COUNT-1:0]     issue_pkt_i,

    output cdb_pkg::cdb_info_t   [`CDB_PORT_COUNT-1:0]   cdb_o
);

    // issue fifo -> alu
    logic [`CDB_FU_COUNT-1:0]                    iq_valid;
    logic [`CDB_FU_COUNT-1:0]                    iq_ready;
    cdb_pkg::issue_pkt_t  [`CDB_FU_COUNT-1:0]    iq_pkt;

    // alu -> result fifo
    logic [`CDB_FU_COUNT-1:0]                    alu_valid;
    logic [`CDB_FU_COUNT-1:0]                    alu_ready;
    cdb_pkg::result_pkt_t [`CDB_FU_COUNT-1:0]    alu_pkt;

    // result fifo -> arbiter
    logic [`CDB_FU_COUNT-1:0]                    rq_valid;
    logic [`CDB_FU_COUNT-1:0]                    rq_pop;
    cdb_pkg::result_pkt_t [`CDB_FU_COUNT-1:0]    rq_pkt;

    for (genvar i = 0; i < `CDB_FU_COUNT; i++) begin : gen_lane

        stage_fifo #(
            .T(cdb_pkg::issue_pkt_t)
        ) issue_fifo_inst (
            .clk        (clk),
            .rst_n_i    (rst_n_i),
            .flush_i    (flush_i),
            .in_valid_i (issue_valid_i[i]),
            .in_ready_o (issue_ready_o[i]),
            .in_data_i  (issue_pkt_i[i]),
            .out_valid_o(iq_valid[i]),
            .out_ready_i(iq_ready[i]),
            .out_data_o (iq_pkt[i])
        );

        alu_stage alu_stage_inst (
            .clk        (clk),
            .rst_n_i    (rst_n_i),
            .flush_i    (flush_i),
            .in_valid_i (iq_valid[i]),
            .in_ready_o (iq_ready[i]),
            .in_pkt_i   (iq_pkt[i]),
            .out_valid_o(alu_valid[i]),
            .out_ready_i(alu_ready[i]),
            .out_pkt_o  (alu_pkt[i])
        );

        // results wait here for a cdb slot
        stage_fifo #(
            .T(cdb_pkg::result_pkt_t)
        ) result_fifo_inst (
            .clk        (clk),
            .rst_n_i    (rst_n_i),
            .flush_i    (flush_i),
            .in_valid_i (alu_valid[i]),
            .in_ready_o (alu_ready[i]),
            .in_data_i  (alu_pkt[i]),
            .out_valid_o(rq_valid[i]),
            .out_ready_i(rq_pop[i]),
            .out_data_o (rq_pkt[i])
        );

    end

    cdb_arbiter cdb_arbiter_inst (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .flush_i    (flush_i),
        .req_valid_i(rq_valid),
        .req_pop_o  (rq_pop),
        .req_pkt_i  (rq_pkt),
        .cdb_o      (cdb_o)
    );

endmodule

`default_nettype wire

/* verif/tb_wb_backend.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cdb_params.svh"

module tb_wb_backend;

    localparam int FU_COUNT    = `CDB_FU_COUNT;
    localparam int PORT_COUNT  = `CDB_PORT_COUNT;
    localparam int DATA_W      = `CDB_DATA_W;
    localparam int LANE_W      = $clog2(FU_COUNT);
    localparam int SEQ_W       = `CDB_ROB_ID_W - LANE_W;
    localparam int CLK_PERIOD  = 40;
    localparam int N_FIXED     = 16;
    localparam int N_ROWS      = N_FIXED + 96;
    localparam int MAIN_END    = 72;  // rows before this run and drain normally
    localparam int FLUSH_END   = 88;  // rows up to here get flushed mid-flight
    localparam int DRAIN_LIMIT = 200;
    localparam int TIMEOUT_CYC = N_ROWS * 20 + 400;

    logic                                 clk;
    logic                                 rst_n;
    logic                                 flush;
    logic [FU_COUNT-1:0]                  issue_valid;
    logic [FU_COUNT-1:0]                  issue_ready;
    cdb_pkg::issue_pkt_t [FU_COUNT-1:0]   issue_pkt;
    logic [FU_COUNT-1:0][DATA_W-1:0]      exp_data;
    cdb_pkg::cdb_info_t [PORT_COUNT-1:0]  cdb;

    // stimulus table, one operation per row
    logic [LANE_W-1:0]  row_lane [N_ROWS];
    cdb_pkg::alu_op_e   row_op   [N_ROWS];
    logic [DATA_W-1:0]  row_a    [N_ROWS];
    logic [DATA_W-1:0]  row_b    [N_ROWS];
    logic [DATA_W-1:0]  row_exp  [N_ROWS];
    int                 n_loaded;

    logic [SEQ_W-1:0]     seq_cnt [FU_COUNT];
    logic [31:0]          lcg_state;
    int                   flow_errors;
    int                   mismatch_count;
    int                   monitor_errors;
    int                   pending;
    int                   assert_fails;
    logic [FU_COUNT-1:0]  stall_seen;
    logic [FU_COUNT-1:0]  resume_seen;

    wb_backend_top wb_backend_top_inst (
        .clk          (clk),
        .rst_n_i      (rst_n),
        .flush_i      (flush),
        .issue_valid_i(issue_valid),
        .issue_ready_o(issue_ready),
        .issue_pkt_i  (issue_pkt),
        .cdb_o        (cdb)
    );

    wb_monitor wb_monitor_inst (
        .clk             (clk),
        .rst_n_i         (rst_n),
        .flush_i         (flush),
        .issue_valid_i   (issue_valid),
        .issue_ready_i   (issue_ready),
        .issue_pkt_i     (issue_pkt),
        .exp_data_i      (exp_data),
        .cdb_i           (cdb),
        .mismatch_count_o(mismatch_count),
        .error_count_o   (monitor_errors),
        .pending_o       (pending),
        .stall_seen_o    (stall_seen),
        .resume_seen_o   (resume_seen)
    );

    bind cdb_arbiter wb_properties wb_properties_inst (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .flush_i    (flush_i),
        .req_valid_i(req_valid_i),
        .req_pop_i  (req_pop_o),
        .cdb_i      (cdb_o)
    );

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // integer alu rule for the random rows
    function automatic logic [DATA_W-1:0] alu_ref(input cdb_pkg::alu_op_e op,
                                                   input logic [DATA_W-1:0] a,
                                                   input logic [DATA_W-1:0] b);
        case (op)
            cdb_pkg::alu_add: return a + b;
            cdb_pkg::alu_sub: return a - b;
            cdb_pkg::alu_and: return a & b;
            cdb_pkg::alu_or:  return a | b;
            cdb_pkg::alu_xor: return a ^ b;
            cdb_pkg::alu_sll: return a << b[4:0];
            cdb_pkg::alu_srl: return a >> b[4:0];
            default:          return ($signed(a) < $signed(b)) ? DATA_W'(1) : DATA_W'(0);
        endcase
    endfunction

    task automatic add_row(input logic [LANE_W-1:0] lane, input cdb_pkg::alu_op_e op,
                           input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b,
                           input logic [DATA_W-1:0] expected);
        row_lane[n_loaded] = lane;
        row_op[n_loaded]   = op;
        row_a[n_loaded]    = a;
        row_b[n_loaded]    = b;
        row_exp[n_loaded]  = expected;
        n_loaded++;
    endtask

    task automatic build_table();
        cdb_pkg::alu_op_e  op;
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;

        add_row(2'd0, cdb_pkg::alu_add, 32'h0000_0005, 32'h0000_0007, 32'h0000_000c);
        add_row(2'd1, cdb_pkg::alu_add, 32'hffff_ffff, 32'h0000_0001, 32'h0000_0000);
        add_row(2'd2, cdb_pkg::alu_sub, 32'h0000_0003, 32'h0000_0005, 32'hffff_fffe);
        add_row(2'd3, cdb_pkg::alu_sub, 32'h8000_0000, 32'h0000_0001, 32'h7fff_ffff);
        add_row(2'd0, cdb_pkg::alu_and, 32'hf0f0_f0f0, 32'hff00_ff00, 32'hf000_f000);
        add_row(2'd1, cdb_pkg::alu_or,  32'h0f0f_0000, 32'h0000_00f0, 32'h0f0f_00f0);
        add_row(2'd2, cdb_pkg::alu_xor, 32'haaaa_aaaa, 32'hffff_0000, 32'h5555_aaaa);
        add_row(2'd3, cdb_pkg::alu_sll, 32'h0000_0001, 32'h0000_001f, 32'h8000_0000);
        add_row(2'd0, cdb_pkg::alu_sll, 32'h0000_0003, 32'h0000_0024, 32'h0000_0030); // 36 -> 4
        add_row(2'd1, cdb_pkg::alu_srl, 32'h8000_0000, 32'h0000_001f, 32'h0000_0001);
        add_row(2'd2, cdb_pkg::alu_srl, 32'hf000_0000, 32'h0000_0004, 32'h0f00_0000);
        add_row(2'd3, cdb_pkg::alu_slt, 32'hffff_ffff, 32'h0000_0001, 32'h0000_0001);
        add_row(2'd0, cdb_pkg::alu_slt, 32'h0000_0001, 32'hffff_ffff, 32'h0000_0000);
        add_row(2'd1, cdb_pkg::alu_slt, 32'h8000_0000, 32'h7fff_ffff, 32'h0000_0001);
        add_row(2'd2, cdb_pkg::alu_slt, 32'h0000_0005, 32'h0000_0005, 32'h0000_0000);
        add_row(2'd3, cdb_pkg::alu_srl, 32'h1234_5678, 32'h0000_0020, 32'h1234_5678); // 32 -> 0
        for (int r = N_FIXED; r < N_ROWS; r++) begin
            lcg_state = lcg_step(lcg_state);
            op        = cdb_pkg::alu_op_e'(lcg_state[18:16]);
            lcg_state = lcg_step(lcg_state);
            a         = lcg_state;
            lcg_state = lcg_step(lcg_state);
            b         = lcg_state;
            add_row(LANE_W'(r % FU_COUNT), op, a, b, alu_ref(op, a, b)); // lanes take turns
        end
    endtask

    function automatic int find_next_row(input int lane, input int from, input int last);
        for (int r = from; r < last; r++) begin
            if (int'(row_lane[r]) == lane) return r;
        end
        return -1;
    endfunction

    // every lane works through its own rows in parallel
    task automatic drive_rows(input int first, input int last);
        int cur [FU_COUNT];
        bit busy;

        for (int l = 0; l < FU_COUNT; l++) cur[l] = find_next_row(l, first, last);
        busy = 1'b1;
        while (busy) begin
            for (int l = 0; l < FU_COUNT; l++) begin
                issue_valid[l] = (cur[l] >= 0);
                if (cur[l] >= 0) begin
                    issue_pkt[l].op     = row_op[cur[l]];
                    issue_pkt[l].src_a  = row_a[cur[l]];
                    issue_pkt[l].src_b  = row_b[cur[l]];
                    issue_pkt[l].rob_id = {LANE_W'(l), seq_cnt[l]};
                    exp_data[l]         = row_exp[cur[l]];
                end
            end
            @(negedge clk);
            busy = 1'b0;
            for (int l = 0; l < FU_COUNT; l++) begin
                if (issue_valid[l] && issue_ready[l]) begin // taken at the coming edge
                    seq_cnt[l] = seq_cnt[l] + 1'b1;
                    cur[l]     = find_next_row(l, cur[l] + 1, last);
                end
                if (cur[l] >= 0) busy = 1'b1;
            end
            @(posedge clk);
            #2;
        end
        issue_valid = '0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic wait_drain(input string phase);
        int waited;

        waited = 0;
        while (pending != 0 && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (pending != 0) begin
            flow_errors++;
            $display("ERROR: %0d results never reached the CDB in the %s phase", pending, phase);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    initial begin
        repeat (TIMEOUT_CYC) @(posedge clk);
        $display("ERROR: run timed out after %0d cycles before all tests finished", TIMEOUT_CYC);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        rst_n       = 1'b0;
        flush       = 1'b0;
        issue_valid = '0;
        issue_pkt   = '0;
        exp_data    = '0;
        flow_errors = 0;
        n_loaded    = 0;
        lcg_state   = 32'd18778;
        for (int l = 0; l < FU_COUNT; l++) seq_cnt[l] = '0;
        build_table();

        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;
        idle_cycles(2);

        drive_rows(0, MAIN_END); // all lanes loaded at once
        wait_drain("main");
        if (stall_seen != '1 || resume_seen != '1) begin
            flow_errors++;
            $display("ERROR: issue ready did not drop and recover on every lane under load");
        end

        drive_rows(MAIN_END, FLUSH_END);
        flush = 1'b1; // results of these rows still in flight
        idle_cycles(1);
        flush = 1'b0;
        idle_cycles(2);
        drive_rows(FLUSH_END, N_ROWS);
        wait_drain("post-flush");
        idle_cycles(4);

        assert_fails = wb_backend_top_inst.cdb_arbiter_inst.wb_properties_inst.fail_count;
        $display("errors: mismatch %0d, unexpected %0d, assertion %0d, flow %0d",
                 mismatch_count, monitor_errors, assert_fails, flow_errors);
        if (mismatch_count + monitor_errors + assert_fails + flow_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verif/wb_monitor.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cdb_params.svh"

module wb_monitor (
    input  logic                                          clk,
    input  logic                                          rst_n_i,
    input  logic                                          flush_i,
    input  logic [`CDB_FU_COUNT-1:0]                      issue_valid_i,
    input  logic [`CDB_FU_COUNT-1:0]                      issue_ready_i,
    input  cdb_pkg::issue_pkt_t [`CDB_FU_COUNT-1:0]       issue_pkt_i,
    input  logic [`CDB_FU_COUNT-1:0][`CDB_DATA_W-1:0]     exp_data_i,
    input  cdb_pkg::cdb_info_t  [`CDB_PORT_COUNT-1:0]     cdb_i,
    output int                                            mismatch_count_o,
    output int                                            error_count_o,
    output int                                            pending_o,
    output logic [`CDB_FU_COUNT-1:0]                      stall_seen_o,
    output logic [`CDB_FU_COUNT-1:0]                      resume_seen_o
);

    localparam int LANE_W = $clog2(`CDB_FU_COUNT);

    cdb_pkg::result_pkt_t exp_q [`CDB_FU_COUNT][$]; // outstanding results per lane
    logic                 reset_seen;

    // everything is sampled mid-cycle away from the driving edge
    always @(negedge clk) begin : check_cycle
        int                   lane;
        int                   total;
        cdb_pkg::result_pkt_t head;
        cdb_pkg::result_pkt_t entry;

        if (!rst_n_i) begin
            reset_seen       = 1'b1;
            mismatch_count_o = 0;
            error_count_o    = 0;
            stall_seen_o     = '0;
            resume_seen_o    = '0;
            for (int l = 0; l < `CDB_FU_COUNT; l++) exp_q[l].delete();
        end else begin
            if (reset_seen) begin // first cycle out of reset
                reset_seen = 1'b0;
                if (!(&issue_ready_i)) begin
                    error_count_o++;
                    $display("ERROR at %0t: issue ready not high on every lane after reset",
                             $time);
                end
                for (int p = 0; p < `CDB_PORT_COUNT; p++) begin
                    if (cdb_i[p].valid) begin
                        error_count_o++;
                        $display("ERROR at %0t: CDB port %0d valid right after reset", $time, p);
                    end
                end
            end
            for (int p = 0; p < `CDB_PORT_COUNT; p++) begin
                if (cdb_i[p].valid) begin
                    lane = int'(cdb_i[p].rob_id[`CDB_ROB_ID_W-1 -: LANE_W]);
                    if (exp_q[lane].size() == 0) begin
                        error_count_o++;
                        $display("ERROR at %0t: port %0d sent tag %0h but lane %0d owes nothing",
                                 $time, p, cdb_i[p].rob_id, lane);
                    end else begin
                        head = exp_q[lane].pop_front();
                        if (head.rob_id != cdb_i[p].rob_id || head.data != cdb_i[p].data) begin
                            mismatch_count_o++;
                            $display("MISMATCH at %0t: port %0d got %0h/%08h, expected %0h/%08h",
                                     $time, p, cdb_i[p].rob_id, cdb_i[p].data,
                                     head.rob_id, head.data);
                        end
                    end
                end
            end
            if (flush_i) begin
                // all in flight is dropped
                for (int l = 0; l < `CDB_FU_COUNT; l++) begin
                    exp_q[l].delete();
                end
            end else begin
                for (int l = 0; l < `CDB_FU_COUNT; l++) begin
                    if (issue_valid_i[l] && issue_ready_i[l]) begin
                        entry.rob_id = issue_pkt_i[l].rob_id;
                        entry.data   = exp_data_i[l];
                        exp_q[l].push_back(entry);
                    end
                end
            end
            for (int l = 0; l < `CDB_FU_COUNT; l++) begin
                if (issue_valid_i[l] && !issue_ready_i[l]) begin
                    stall_seen_o[l] = 1'b1;
                end else if (stall_seen_o[l] && issue_ready_i[l]) begin
                    resume_seen_o[l] = 1'b1;
                end
            end
        end
        total = 0;
        for (int l = 0; l < `CDB_FU_COUNT; l++) total += exp_q[l].size();
        pending_o = total;
    end

endmodule

`default_nettype wire

/* verif/wb_properties.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cdb_params.svh"

module wb_properties (
    input  logic                                       clk,
    input  logic                                       rst_n_i,
    input  logic                                       flush_i,
    input  logic [`CDB_FU_COUNT-1:0]                   req_valid_i,
    input  logic [`CDB_FU_COUNT-1:0]                   req_pop_i,
    input  cdb_pkg::cdb_info_t [`CDB_PORT_COUNT-1:0]   cdb_i
);

    logic [`CDB_PORT_COUNT-1:0] cdb_valid;
    int                         fail_count = 0; // read by the testbench at the end

    always_comb begin
        for (int p = 0; p < `CDB_PORT_COUNT; p++) begin
            cdb_valid[p] = cdb_i[p].valid;
        end
    end

    // a pop only drains a lane that has a result
    pop_needs_valid: assert property (@(posedge clk) disable iff (!rst_n_i)
        (req_pop_i & ~req_valid_i) == '0)
    else begin
        fail_count++;
        $error("arbiter popped a lane with no valid result");
    end

    pop_limit: assert property (@(posedge clk) disable iff (!rst_n_i)
        $countones(req_pop_i) <= `CDB_PORT_COUNT)
    else begin
        fail_count++;
        $error("arbiter popped more lanes than there are CDB ports");
    end

    // bus goes quiet right after a flush
    flush_clears_cdb: assert property (@(posedge clk) disable iff (!rst_n_i)
        flush_i |=> (cdb_valid == '0))
    else begin
        fail_count++;
        $error("CDB valid high in the cycle after a flush");
    end

endmodule

`default_nettype wire
